//--- design/snowball_pkg.sv
package snowball_pkg;

  // --------------------------------------------------
  // address fields
  // --------------------------------------------------
  localparam int idx_w  = 8;   // cache and table index
  localparam int vtag_w = 14;  // virtual and physical page number
  localparam int ctag_w = 22;  // cache tag, paddr[31:10]

  localparam int word_lsb  = 2;   // word index at [9:2]
  localparam int tlb_lsb   = 10;  // table index at [17:10], cache tag starts here
  localparam int vpage_lsb = 18;  // page number at [31:18]

  // memory request credits out of reset
  localparam int mem_credits_dflt = 2;

  // --------------------------------------------------
  // entry layouts
  // --------------------------------------------------
  typedef logic [31:0] cache_data_t;  // one word per line

  typedef struct packed {
    logic              valid;
    logic [ctag_w-1:0] tag;  // physical tag
  } cache_tag_t;

  // tlb_wdata[28] valid, [27:14] vtag, [13:0] ptag
  typedef struct packed {
    logic              valid;
    logic [vtag_w-1:0] vtag;
    logic [vtag_w-1:0] ptag;
  } tlb_entry_t;

endpackage

//--- design/cache_ifs.sv
// --------------------------------------------------
// controller <-> cache storage
// --------------------------------------------------
interface cache_lookup_if;
  logic                            rd_en;
  logic [snowball_pkg::idx_w-1:0]  rd_idx;
  logic [snowball_pkg::ctag_w-1:0] cmp_tag;  // tag of the translated address
  logic                            wr_en;    // refill or write allocate
  logic [snowball_pkg::idx_w-1:0]  wr_idx;
  logic [snowball_pkg::ctag_w-1:0] wr_tag;
  snowball_pkg::cache_data_t       wr_data;
  logic                            hit;
  snowball_pkg::cache_data_t       rd_data;

  modport ctrl (output rd_en, rd_idx, cmp_tag, wr_en, wr_idx, wr_tag, wr_data,
                input  hit, rd_data);
  modport array (input  rd_en, rd_idx, cmp_tag, wr_en, wr_idx, wr_tag, wr_data,
                 output hit, rd_data);
endinterface

// --------------------------------------------------
// controller <-> translation table
// --------------------------------------------------
interface tlb_lookup_if;
  logic                            rd_en;
  logic [snowball_pkg::idx_w-1:0]  rd_idx;
  logic [snowball_pkg::vtag_w-1:0] vpage;  // page of the pending request
  logic                            ld_en;
  logic [snowball_pkg::idx_w-1:0]  ld_idx;
  snowball_pkg::tlb_entry_t        ld_entry;
  logic [snowball_pkg::vtag_w-1:0] ptag;
  logic                            tag_match;

  modport ctrl (output rd_en, rd_idx, vpage, ld_en, ld_idx, ld_entry,
                input  ptag, tag_match);
  modport array (input  rd_en, rd_idx, vpage, ld_en, ld_idx, ld_entry,
                 output ptag, tag_match);
endinterface

//--- design/lookup_ram.sv
module lookup_ram #(
  parameter type entry_t = logic [31:0]
) (
  input  logic                           CPU_CLK,
  input  logic                           RST,
  input  logic                           rd_en,
  input  logic [snowball_pkg::idx_w-1:0] rd_idx,
  output entry_t                         rd_data,
  input  logic                           wr_en,
  input  logic [snowball_pkg::idx_w-1:0] wr_idx,
  input  entry_t                         wr_data
);

  localparam int depth = 1 << snowball_pkg::idx_w;

  entry_t           mem [depth];
  logic [depth-1:0] written;  // entry holds data since reset

  always_ff @(posedge CPU_CLK)
  begin
    if (wr_en)
      mem[wr_idx] <= wr_data;
  end

  // whole vector swept clear in reset
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      written <= '0;
    else if (wr_en)
      written[wr_idx] <= 1'b1;
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (rd_en)
    begin
      if (wr_en && (wr_idx == rd_idx))
        rd_data <= wr_data;      // same cycle write forwarded
      else if (written[rd_idx])
        rd_data <= mem[rd_idx];
      else
        rd_data <= '0;           // untouched entry reads as zero
    end
  end

endmodule

//--- design/cache_array.sv
module cache_array (
  input logic           CPU_CLK,
  input logic           RST,
  cache_lookup_if.array lk
);

  snowball_pkg::cache_tag_t rd_tag;
  snowball_pkg::cache_tag_t wr_tag;

  // a written line is always valid
  assign wr_tag.valid = 1'b1;
  assign wr_tag.tag   = lk.wr_tag;

  // --------------------------------------------------
  // data and tag read side by side
  // --------------------------------------------------
  lookup_ram #(
    .entry_t (snowball_pkg::cache_data_t)
  ) u_data_ram (
    .CPU_CLK (CPU_CLK),
    .RST     (RST),
    .rd_en   (lk.rd_en),
    .rd_idx  (lk.rd_idx),
    .rd_data (lk.rd_data),
    .wr_en   (lk.wr_en),
    .wr_idx  (lk.wr_idx),
    .wr_data (lk.wr_data)
  );

  lookup_ram #(
    .entry_t (snowball_pkg::cache_tag_t)
  ) u_tag_ram (
    .CPU_CLK (CPU_CLK),
    .RST     (RST),
    .rd_en   (lk.rd_en),
    .rd_idx  (lk.rd_idx),
    .rd_data (rd_tag),
    .wr_en   (lk.wr_en),   // tag and data land together
    .wr_idx  (lk.wr_idx),
    .wr_data (wr_tag)
  );

  // cmp_tag follows the table output in the same cycle
  assign lk.hit = rd_tag.valid && (rd_tag.tag == lk.cmp_tag);

endmodule

//--- design/tlb_array.sv
module tlb_array (
  input logic         CPU_CLK,
  input logic         RST,
  tlb_lookup_if.array lk
);

  snowball_pkg::tlb_entry_t rd_entry;

  // --------------------------------------------------
  // page table storage
  // --------------------------------------------------
  lookup_ram #(
    .entry_t (snowball_pkg::tlb_entry_t)
  ) u_tlb_ram (
    .CPU_CLK (CPU_CLK),
    .RST     (RST),
    .rd_en   (lk.rd_en),
    .rd_idx  (lk.rd_idx),
    .rd_data (rd_entry),
    .wr_en   (lk.ld_en),     // table load from the cpu side
    .wr_idx  (lk.ld_idx),
    .wr_data (lk.ld_entry)
  );

  // virtual tag check against the registered request page
  assign lk.tag_match = rd_entry.valid && (rd_entry.vtag == lk.vpage);

  // physical page, meaningful only on a match
  assign lk.ptag = rd_entry.ptag;

endmodule

//--- design/miss_ctrl.sv
module miss_ctrl #(
  parameter int MEM_CREDITS = snowball_pkg::mem_credits_dflt
) (
  input  logic         CPU_CLK,
  input  logic         RST,
  input  logic         cpu_req_valid,
  input  logic         cpu_req_we,
  input  logic         cache_inhibit,
  input  logic         vmem_act,
  input  logic         tlb_load,
  input  logic         mem_credit,
  input  logic         mem_rsp_valid,
  input  logic [31:0]  cpu_req_addr,
  input  logic [31:0]  cpu_req_wdata,
  input  logic [31:0]  tlb_wdata,
  input  logic [31:0]  mem_rsp_data,
  output logic         cpu_busy,
  output logic         cpu_rsp_valid,
  output logic         mmu_fault,
  output logic         mem_req_valid,
  output logic         mem_req_we,
  output logic [31:0]  cpu_rsp_data,
  output logic [31:0]  mem_req_addr,
  output logic [31:0]  mem_req_wdata,
  cache_lookup_if.ctrl cl,
  tlb_lookup_if.ctrl   tl
);

  localparam int cnt_w     = $clog2(MEM_CREDITS + 1);
  localparam int idx_w     = snowball_pkg::idx_w;
  localparam int vtag_w    = snowball_pkg::vtag_w;
  localparam int ctag_w    = snowball_pkg::ctag_w;
  localparam int word_lsb  = snowball_pkg::word_lsb;
  localparam int tlb_lsb   = snowball_pkg::tlb_lsb;
  localparam int vpage_lsb = snowball_pkg::vpage_lsb;

  typedef enum logic [2:0] {
    idle,
    lookup,       // ram outputs valid, translate and compare
    decide,
    wait_credit,  // memory channel out of credits
    wait_rsp
  } state_t;

  state_t           state;
  logic [cnt_w-1:0] credits;
  logic             got_q;  // read data back, respond next cycle

  logic [31:0]      addr_q;
  logic [31:0]      wdata_q;
  logic [31:0]      paddr_q;
  logic [31:0]      rsp_data_q;
  logic             we_q;
  logic             inh_q;
  logic             vmem_q;
  logic             hit_q;
  logic             fault_q;

  logic             accept;
  logic             rd_hit;
  logic             need_mem;
  logic [31:0]      paddr;

  // --------------------------------------------------
  // request capture and lookups
  // --------------------------------------------------
  assign accept = (state == idle) && cpu_req_valid && !tlb_load;  // load wins

  assign tl.rd_en    = accept;
  assign tl.rd_idx   = cpu_req_addr[tlb_lsb +: idx_w];
  assign tl.vpage    = addr_q[vpage_lsb +: vtag_w];
  assign tl.ld_en    = (state == idle) && tlb_load;
  assign tl.ld_idx   = cpu_req_addr[tlb_lsb +: idx_w];
  assign tl.ld_entry = tlb_wdata[$bits(snowball_pkg::tlb_entry_t)-1:0];

  assign paddr = vmem_q ? {tl.ptag, addr_q[vpage_lsb-1:0]} : addr_q;

  assign cl.rd_en   = accept;
  assign cl.rd_idx  = cpu_req_addr[word_lsb +: idx_w];
  assign cl.cmp_tag = paddr[tlb_lsb +: ctag_w];

  // --------------------------------------------------
  // decision and outputs
  // --------------------------------------------------
  assign rd_hit   = hit_q && !we_q && !inh_q && !fault_q;
  assign need_mem = !fault_q && !rd_hit;

  assign mem_req_valid = (((state == decide) && need_mem) || (state == wait_credit))
                         && (credits != '0);

  assign cpu_busy      = (state != idle);
  assign cpu_rsp_valid = ((state == decide) && rd_hit) || ((state == wait_rsp) && got_q);
  assign mmu_fault     = (state == decide) && fault_q;
  assign cpu_rsp_data  = rsp_data_q;

  assign mem_req_addr  = paddr_q;
  assign mem_req_we    = we_q;
  assign mem_req_wdata = wdata_q;

  // write allocate at issue, refill with the response
  assign cl.wr_en   = !inh_q && ((mem_req_valid && we_q) || ((state == wait_rsp) && got_q));
  assign cl.wr_idx  = paddr_q[word_lsb +: idx_w];
  assign cl.wr_tag  = paddr_q[tlb_lsb +: ctag_w];
  assign cl.wr_data = got_q ? rsp_data_q : wdata_q;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state <= idle;
      got_q <= 1'b0;
    end
    else
    begin
      case (state)
        idle:
          if (accept)
            state <= lookup;
        lookup:
          state <= decide;
        decide, wait_credit:
          if ((state == decide) && !need_mem)
            state <= idle;                      // hit or fault
          else if (mem_req_valid)
            state <= we_q ? idle : wait_rsp;    // writes end at issue
          else
            state <= wait_credit;
        wait_rsp:
          if (got_q)
          begin
            state <= idle;
            got_q <= 1'b0;
          end
          else if (mem_rsp_valid)
            got_q <= 1'b1;
        default:
          state <= idle;
      endcase
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      addr_q  <= cpu_req_addr;
      wdata_q <= cpu_req_wdata;
      we_q    <= cpu_req_we;
      inh_q   <= cache_inhibit;
      vmem_q  <= vmem_act;
    end
    if (state == lookup)
    begin
      paddr_q    <= paddr;
      hit_q      <= cl.hit;
      fault_q    <= vmem_q && !tl.tag_match;
      rsp_data_q <= cl.rd_data;
    end
    else if ((state == wait_rsp) && mem_rsp_valid && !got_q)
      rsp_data_q <= mem_rsp_data;
  end

  // --------------------------------------------------
  // memory credits
  // --------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      credits <= cnt_w'(MEM_CREDITS);
    else
    begin
      case ({mem_req_valid, mem_credit})
        2'b10:   credits <= credits - cnt_w'(1);
        2'b01:   credits <= credits + cnt_w'(1);
        default: credits <= credits;  // none, or spend and return together
      endcase
    end
  end

endmodule

//--- design/mmu_cache_top.sv
module mmu_cache_top #(
  parameter int MEM_CREDITS = snowball_pkg::mem_credits_dflt
) (
  input  logic        CPU_CLK,
  input  logic        RST,
  // cpu side
  input  logic        cpu_req_valid,
  input  logic        cpu_req_we,
  input  logic        cache_inhibit,
  input  logic        vmem_act,
  input  logic        tlb_load,
  input  logic [31:0] cpu_req_addr,
  input  logic [31:0] cpu_req_wdata,
  input  logic [31:0] tlb_wdata,
  output logic        cpu_busy,
  output logic        cpu_rsp_valid,
  output logic        mmu_fault,
  output logic [31:0] cpu_rsp_data,
  // memory side
  input  logic        mem_credit,
  input  logic        mem_rsp_valid,
  input  logic [31:0] mem_rsp_data,
  output logic        mem_req_valid,
  output logic        mem_req_we,
  output logic [31:0] mem_req_addr,
  output logic [31:0] mem_req_wdata
);

  cache_lookup_if cl_if ();
  tlb_lookup_if   tl_if ();

  // --------------------------------------------------
  // two lookups in parallel, one controller
  // --------------------------------------------------
  cache_array u_cache_array (
    .CPU_CLK (CPU_CLK),
    .RST     (RST),
    .lk      (cl_if)
  );

  tlb_array u_tlb_array (
    .CPU_CLK (CPU_CLK),
    .RST     (RST),
    .lk      (tl_if)
  );

  miss_ctrl #(
    .MEM_CREDITS (MEM_CREDITS)
  ) u_miss_ctrl (
    .CPU_CLK       (CPU_CLK),
    .RST           (RST),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req_we    (cpu_req_we),
    .cache_inhibit (cache_inhibit),
    .vmem_act      (vmem_act),
    .tlb_load      (tlb_load),
    .mem_credit    (mem_credit),
    .mem_rsp_valid (mem_rsp_valid),
    .cpu_req_addr  (cpu_req_addr),
    .cpu_req_wdata (cpu_req_wdata),
    .tlb_wdata     (tlb_wdata),
    .mem_rsp_data  (mem_rsp_data),
    .cpu_busy      (cpu_busy),
    .cpu_rsp_valid (cpu_rsp_valid),
    .mmu_fault     (mmu_fault),
    .mem_req_valid (mem_req_valid),
    .mem_req_we    (mem_req_we),
    .cpu_rsp_data  (cpu_rsp_data),
    .mem_req_addr  (mem_req_addr),
    .mem_req_wdata (mem_req_wdata),
    .cl            (cl_if),
    .tl            (tl_if)
  );

endmodule

//--- tb/mmu_cache_chk.sv
module mmu_cache_chk #(
  parameter int MEM_CREDITS = 2
) (
  input logic                               CPU_CLK,
  input logic                               RST,
  input logic [$clog2(MEM_CREDITS+1)-1:0]   credits,
  input logic                               mem_req_valid,
  input logic                               mem_credit,
  input logic                               cpu_rsp_valid,
  input logic                               mmu_fault
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int cnt_w = $clog2(MEM_CREDITS + 1);

  logic [cnt_w-1:0] in_flight;  // requests not yet credited back

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      in_flight <= '0;
    else
      in_flight <= in_flight + cnt_w'(mem_req_valid) - cnt_w'(mem_credit);
  end

  // --------------------------------------------------
  // credit channel
  // --------------------------------------------------
  credit_bound: assert property (@(posedge CPU_CLK) disable iff (!RST)
    credits <= cnt_w'(MEM_CREDITS))
    else $error("credit count above its limit");

  no_req_without_credit: assert property (@(posedge CPU_CLK) disable iff (!RST)
    mem_req_valid |-> (in_flight < cnt_w'(MEM_CREDITS)))
    else $error("memory request issued with no credit left");

  // a request ends either way, never both
  rsp_or_fault: assert property (@(posedge CPU_CLK) disable iff (!RST)
    !(cpu_rsp_valid && mmu_fault))
    else $error("response and fault in the same cycle");

endmodule

bind miss_ctrl mmu_cache_chk #(
  .MEM_CREDITS (MEM_CREDITS)
) u_chk (
  .CPU_CLK       (CPU_CLK),
  .RST           (RST),
  .credits       (credits),
  .mem_req_valid (mem_req_valid),
  .mem_credit    (mem_credit),
  .cpu_rsp_valid (cpu_rsp_valid),
  .mmu_fault     (mmu_fault)
);

//--- tb/tb_mmu_cache.sv
module tb_mmu_cache;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int mem_credits = 1;    // one credit, so a write burst stalls
  localparam int timeout_cyc = 200;
  localparam int burst_first = 12;   // table entries from here on form the burst

  typedef enum logic [1:0] {op_load, op_read, op_write, op_inh} op_kind_t;
  typedef struct packed {
    op_kind_t    kind;
    logic [31:0] addr;
    logic        vmem;
    logic        exp_hit;
    logic [31:0] ld_data;   // table entry for a load
  } op_t;

  logic        CPU_CLK, RST;
  logic        cpu_req_valid, cpu_req_we, cache_inhibit, vmem_act, tlb_load;
  logic [31:0] cpu_req_addr, cpu_req_wdata, tlb_wdata;
  logic        cpu_busy, cpu_rsp_valid, mmu_fault;
  logic [31:0] cpu_rsp_data;
  logic        mem_credit = 1'b0;
  logic        mem_rsp_valid = 1'b0;
  logic [31:0] mem_rsp_data = '0;
  logic        mem_req_valid, mem_req_we;
  logic [31:0] mem_req_addr, mem_req_wdata;

  logic [31:0] mem_words [1024];   // memory model storage
  logic [31:0] ref_mem [1024];
  logic [28:0] ref_tlb [256];
  int          cyc = 0;
  int          req_cnt = 0;
  logic [31:0] wr_log [$];         // write addresses in issue order
  int          rsp_due [$];
  logic [31:0] rsp_val [$];
  int          crd_due [$];
  op_t         ops [$];
  int          errors = 0;
  int          tests = 0;
  logic        timed_out = 1'b0;

  mmu_cache_top #(
    .MEM_CREDITS (mem_credits)
  ) UUT (.*);

  always #4 CPU_CLK = ~CPU_CLK;

  // --------------------------------------------------
  // memory model
  // --------------------------------------------------
  always @(posedge CPU_CLK)
  begin
    cyc = cyc + 1;
    if (RST && mem_req_valid)
    begin
      req_cnt = req_cnt + 1;
      crd_due.push_back(cyc + 4);  // credit back after 4 cycles
      if (mem_req_we)
      begin
        mem_words[mem_req_addr[11:2]] = mem_req_wdata;
        wr_log.push_back(mem_req_addr);
      end
      else
      begin
        rsp_due.push_back(cyc + 3);  // fixed read latency
        rsp_val.push_back(mem_words[mem_req_addr[11:2]]);
      end
    end
    #1;
    mem_credit    = 1'b0;
    mem_rsp_valid = 1'b0;
    if ((crd_due.size() > 0) && (crd_due[0] == cyc))
    begin
      void'(crd_due.pop_front());
      mem_credit = 1'b1;
    end
    if ((rsp_due.size() > 0) && (rsp_due[0] == cyc))
    begin
      void'(rsp_due.pop_front());
      mem_rsp_valid = 1'b1;
      mem_rsp_data  = rsp_val.pop_front();
    end
  end

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic logic [31:0] fill_word(input int idx);
    logic [31:0] a;
    a = 32'(idx) << 2;
    return 32'h5a00_0000 ^ (a * 32'h0100_0193);  // whole address folded in
  endfunction

  function automatic logic [31:0] xlate(input logic [31:0] a, input logic vm);
    logic [28:0] e;
    e = ref_tlb[a[17:10]];
    return vm ? {e[13:0], a[17:0]} : a;
  endfunction

  function automatic logic faults(input logic [31:0] a, input logic vm);
    logic [28:0] e;
    e = ref_tlb[a[17:10]];
    return vm && !(e[28] && (e[27:14] == a[31:18]));
  endfunction

  function automatic op_t mk(input op_kind_t k, input logic [31:0] a, input logic vm,
                             input logic h, input logic [31:0] d);
    op_t o;
    o.kind    = k;
    o.addr    = a;
    o.vmem    = vm;
    o.exp_hit = h;
    o.ld_data = d;
    return o;
  endfunction

  task automatic flag_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    $display("Mismatch %s exp %h got %h", name, exp, got);
    errors++;
  endtask

  task automatic note_error(input string what);
    $display("%s", what);
    errors++;
  endtask

  task automatic wait_idle(output int n);
    n = 0;
    while (cpu_busy && (n < timeout_cyc))
    begin
      @(posedge CPU_CLK);
      #1;
      n++;
    end
    if (cpu_busy)
    begin
      $display("timeout: cpu_busy stayed high");
      timed_out = 1'b1;
    end
  endtask

  task automatic run_op(input op_t op, output int lat);
    logic [31:0] pa;
    logic [31:0] wd;
    logic [31:0] rsp;
    logic        flt;
    logic        got_rsp;
    logic        got_flt;
    int          req0;
    int          req_exp;
    int          n;
    pa  = xlate(op.addr, op.vmem);
    flt = faults(op.addr, op.vmem);
    lat = 0;
    rsp = '0;
    wait_idle(n);
    req0         = req_cnt;
    cpu_req_addr = op.addr;
    vmem_act     = op.vmem;
    if (op.kind == op_load)
    begin
      tlb_load  = 1'b1;
      tlb_wdata = op.ld_data;
      @(posedge CPU_CLK);
      #1;
      tlb_load = 1'b0;
      ref_tlb[op.addr[17:10]] = op.ld_data[28:0];
    end
    else if (op.kind == op_write)
    begin
      wd            = $urandom;
      cpu_req_wdata = wd;
      cpu_req_we    = 1'b1;
      cpu_req_valid = 1'b1;
      @(posedge CPU_CLK);
      #1;
      cpu_req_valid = 1'b0;
      wait_idle(lat);
      ref_mem[pa[11:2]] = wd;
      assert (req_cnt == req0 + 1)
        else flag_mismatch("mem_req_valid count", 32'(req0 + 1), 32'(req_cnt));
      assert (mem_words[pa[11:2]] == wd)
        else flag_mismatch("mem_req_wdata", wd, mem_words[pa[11:2]]);
      assert ((wr_log.size() > 0) && (wr_log[$] == pa))
        else flag_mismatch("mem_req_addr", pa, (wr_log.size() > 0) ? wr_log[$] : 'x);
    end
    else
    begin
      cpu_req_we    = 1'b0;
      cache_inhibit = (op.kind == op_inh);
      cpu_req_valid = 1'b1;
      @(posedge CPU_CLK);
      #1;
      cpu_req_valid = 1'b0;
      got_rsp = 1'b0;
      got_flt = 1'b0;
      while (!got_rsp && !got_flt && (lat < timeout_cyc))
      begin
        @(negedge CPU_CLK);     // outputs settled mid cycle
        lat++;
        got_rsp = cpu_rsp_valid;
        got_flt = mmu_fault;
        if (got_rsp)
          rsp = cpu_rsp_data;
      end
      @(posedge CPU_CLK);
      #1;
      cache_inhibit = 1'b0;
      if (!got_rsp && !got_flt)
      begin
        $display("timeout: no response for read at %h", op.addr);
        timed_out = 1'b1;
      end
      else if (flt)
      begin
        assert (got_flt) else note_error("expected fault did not occur");
        assert (req_cnt == req0)
          else flag_mismatch("mem_req_valid count", 32'(req0), 32'(req_cnt));
      end
      else
      begin
        req_exp = req0 + (op.exp_hit ? 0 : 1);
        assert (got_rsp) else note_error("unexpected fault on a mapped page");
        assert (rsp == ref_mem[pa[11:2]])
          else flag_mismatch("cpu_rsp_data", ref_mem[pa[11:2]], rsp);
        assert (req_cnt == req_exp)
          else flag_mismatch("mem_req_valid count", 32'(req_exp), 32'(req_cnt));
        assert (op.exp_hit ? (lat == 2) : (lat > 2))
          else note_error($sformatf("response took %0d cycles, wrong for hit=%0d",
                                    lat, op.exp_hit));
      end
    end
  endtask

  // --------------------------------------------------
  // stimulus table and run
  // --------------------------------------------------
  initial
  begin
    int lat;
    int err0;
    int stalls;
    CPU_CLK = 1'b0;
    RST = 1'b0;
    {cpu_req_valid, cpu_req_we, cache_inhibit, vmem_act, tlb_load} = '0;
    cpu_req_addr  = '0;
    cpu_req_wdata = '0;
    tlb_wdata     = '0;
    stalls        = 0;
    void'($urandom(32'h9ad6));
    for (int i = 0; i < 1024; i++)
    begin
      mem_words[i] = fill_word(i);
      ref_mem[i]   = fill_word(i);
    end
    for (int i = 0; i < 256; i++)
      ref_tlb[i] = '0;

    ops.push_back(mk(op_write, 32'h0000_1040, 1'b0, 1'b0, '0));
    ops.push_back(mk(op_read,  32'h0000_1040, 1'b0, 1'b1, '0));  // write allocated
    ops.push_back(mk(op_read,  32'h0000_2080, 1'b0, 1'b0, '0));
    ops.push_back(mk(op_read,  32'h0000_2080, 1'b0, 1'b1, '0));  // refilled
    ops.push_back(mk(op_inh,   32'h0000_30c0, 1'b0, 1'b0, '0));
    ops.push_back(mk(op_inh,   32'h0000_30c0, 1'b0, 1'b0, '0));  // no fill
    ops.push_back(mk(op_read,  32'h0000_30c0, 1'b0, 1'b0, '0));  // line still empty
    ops.push_back(mk(op_read,  32'h0004_0400, 1'b1, 1'b0, '0));  // unmapped page
    ops.push_back(mk(op_load,  32'h0004_0400, 1'b0, 1'b0, {3'b0, 1'b1, 14'd1, 14'd5}));
    ops.push_back(mk(op_read,  32'h0004_0400, 1'b1, 1'b0, '0));
    ops.push_back(mk(op_write, 32'h0004_0410, 1'b1, 1'b0, '0));
    ops.push_back(mk(op_read,  32'h0004_0410, 1'b1, 1'b1, '0));
    for (int i = 0; i < 4; i++)
      ops.push_back(mk(op_write, 32'h0000_0600 + 32'(i * 4), 1'b0, 1'b0, '0));

    repeat (8) @(posedge CPU_CLK);
    #1;
    RST = 1'b1;

    foreach (ops[i])
    begin
      err0 = errors;
      run_op(ops[i], lat);
      tests++;
      if ((i >= burst_first) && (lat > 3))
        stalls++;                              // held busy waiting for a credit
      $display("test %0d kind %0d addr %h: %s", i, ops[i].kind, ops[i].addr,
               (errors == err0) && !timed_out ? "ok" : "error");
      if (timed_out)
        break;
    end

    if (!timed_out)
    begin
      assert (stalls > 0) else note_error("write burst never stalled on credits");
      for (int i = 0; i < 4; i++)
      begin
        assert (wr_log[wr_log.size() - 4 + i] == 32'h0000_0600 + 32'(i * 4))
          else flag_mismatch("mem_req_addr", 32'h0000_0600 + 32'(i * 4),
                             wr_log[wr_log.size() - 4 + i]);
      end
    end

    $display("tests %0d, errors %0d, timeouts %0d", tests, errors, timed_out);
    if ((errors == 0) && !timed_out)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

//--- sources.f
design/snowball_pkg.sv
design/cache_ifs.sv
design/lookup_ram.sv
design/cache_array.sv
design/tlb_array.sv
design/miss_ctrl.sv
design/mmu_cache_top.sv
tb/mmu_cache_chk.sv
tb/tb_mmu_cache.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_mmu_cache
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
